// File: ex_config.svh
// control store layout and EFLAGS bit positions for the execute stage
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// control store word width may still change
`define CS_WIDTH 64

// execute-relevant control store flags
`define CS_BIT_CMPS_FIRST  40
`define CS_BIT_CMPS_SECOND 41
`define CS_BIT_REPNE_FIRST 42
`define CS_BIT_LD_GPR2     43
`define CS_BIT_LD_GPR3     44
`define CS_BIT_LD_FLAGS    45

// EFLAGS bit positions
`define FLAG_CF 0
`define FLAG_PF 2
`define FLAG_AF 4
`define FLAG_ZF 6
`define FLAG_SF 7
`define FLAG_OF 11

`endif

// File: ex_pkg.sv
// ALU op and data size enums with the decode, micro-op and writeback structs
`include "ex_config.svh"

package ex_pkg;

  // ALU operation encoding from decode
  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_or     = 3'd1,
    alu_pass_b = 3'd2,
    alu_not_a  = 3'd3,
    alu_and    = 3'd4,
    alu_sub    = 3'd5,
    alu_xor    = 3'd6,
    alu_pass_a = 3'd7
  } alu_op_e;

  // operand width for flag generation
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_word  = 2'd1,
    size_dword = 2'd2
  } data_size_e;

  // decoded control store flags in MSB-first order
  typedef struct packed {
    logic cmps_first;
    logic cmps_second;
    logic repne_first;
    logic ld_gpr2;
    logic ld_gpr3;
    logic ld_flags;
  } cs_fields_t;

  // micro-op from register read
  typedef struct packed {
    logic                  valid;
    logic [31:0]           neip;
    logic [15:0]           ncs;
    logic [`CS_WIDTH-1:0]  control_store;
    data_size_e            datasize;
    alu_op_e               aluk;
    logic                  mem_wr;
    logic                  ld_gpr1;
    logic                  dcache_write;
    logic [6:0]            flags_affected;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [31:0]           count;
    logic [31:0]           address;
    logic [2:0]            dr1;
    logic [2:0]            dr2;
    logic [2:0]            dr3;
  } ex_uop_t;

  // bundle handed to writeback
  typedef struct packed {
    logic                  valid;
    logic [31:0]           neip;
    logic [15:0]           ncs;
    logic [`CS_WIDTH-1:0]  control_store;
    data_size_e            datasize;
    alu_op_e               aluk;
    logic                  ld_gpr1;
    logic                  dcache_write;
    logic [6:0]            flags_affected;
    logic [31:0]           alu_result;
    logic [31:0]           flags;
    logic [31:0]           cmps_pointer;
    logic [31:0]           count;
    logic [2:0]            dr1;
    logic [2:0]            dr2;
    logic [2:0]            dr3;
  } wb_uop_t;

endpackage

// File: control_store_decode.sv
// control store decoder for the execute and writeback control flags
`timescale 1ns/1ps
`include "ex_config.svh"

module control_store_decode (
  input  logic [`CS_WIDTH-1:0] control_store,
  output logic [5:0]           cs_fields
);

  logic cmps_first_raw;
  logic cmps_second_raw;
  logic cmps_illegal;
  logic cmps_first;
  logic cmps_second;

  assign cmps_first_raw  = control_store[`CS_BIT_CMPS_FIRST];
  assign cmps_second_raw = control_store[`CS_BIT_CMPS_SECOND];

  // a micro-op cannot be both halves of a CMPS
  assign cmps_illegal = cmps_first_raw & cmps_second_raw;

  assign cmps_first  = cmps_first_raw & ~cmps_illegal;
  assign cmps_second = cmps_second_raw & ~cmps_illegal;

  // same order as cs_fields_t with cmps_first in the MSB
  assign cs_fields = {
    cmps_first,
    cmps_second,
    control_store[`CS_BIT_REPNE_FIRST],
    control_store[`CS_BIT_LD_GPR2],
    control_store[`CS_BIT_LD_GPR3],
    control_store[`CS_BIT_LD_FLAGS]
  };

endmodule

// File: alu32.sv
// 32-bit ALU with result and EFLAGS at byte, word or dword width
`timescale 1ns/1ps
`include "ex_config.svh"

module alu32 (
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  ex_pkg::alu_op_e    aluk,
  input  ex_pkg::data_size_e datasize,
  output logic [31:0]        result,
  output logic [31:0]        flags
);
  import ex_pkg::*;

  logic [32:0] sum;
  logic [32:0] diff;
  logic [32:0] arith;
  logic        is_arith;
  logic        is_sub;
  logic        a_top;
  logic        b_top;
  logic        r_top;
  logic        carry;
  logic        zero;
  logic        overflow;

  assign sum   = {1'b0, a} + {1'b0, b};
  assign diff  = {1'b0, a} - {1'b0, b};
  assign arith = is_sub ? diff : sum;

  always_comb begin
    is_arith = 1'b0;
    is_sub   = 1'b0;
    case (aluk)
      alu_add: begin
        result   = sum[31:0];
        is_arith = 1'b1;
      end
      alu_sub: begin
        result   = diff[31:0];
        is_arith = 1'b1;
        is_sub   = 1'b1;
      end
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_xor:    result = a ^ b;
      alu_not_a:  result = ~a;
      alu_pass_b: result = b;
      default:    result = a;
    endcase
  end

  // a^b^r at a bit gives the carry (add) or borrow (sub) into that bit
  always_comb begin
    case (datasize)
      size_byte: begin
        a_top = a[7];
        b_top = b[7];
        r_top = result[7];
        carry = a[8] ^ b[8] ^ arith[8];
        zero  = (result[7:0] == 8'h00);
      end
      size_word: begin
        a_top = a[15];
        b_top = b[15];
        r_top = result[15];
        carry = a[16] ^ b[16] ^ arith[16];
        zero  = (result[15:0] == 16'h0000);
      end
      default: begin
        a_top = a[31];
        b_top = b[31];
        r_top = result[31];
        carry = arith[32];
        zero  = (result == 32'h0000_0000);
      end
    endcase
  end

  // signed overflow from a same-sign add or a mixed-sign sub that flips the sign of a
  assign overflow = is_sub ? ((a_top != b_top) && (r_top != a_top))
                           : ((a_top == b_top) && (r_top != a_top));

  always_comb begin
    flags = '0;
    // no carry chain for logic ops, so CF, AF and OF stay clear
    flags[`FLAG_CF] = is_arith & carry;
    flags[`FLAG_PF] = ~^result[7:0];
    flags[`FLAG_AF] = is_arith & (a[4] ^ b[4] ^ arith[4]);
    flags[`FLAG_ZF] = zero;
    flags[`FLAG_SF] = r_top;
    flags[`FLAG_OF] = is_arith & overflow;
  end

endmodule

// File: cmps_operand_select.sv
// CMPS first-operand holding register and ALU operand B mux
`timescale 1ns/1ps

module cmps_operand_select (
  input  logic        clk,
  input  logic        reset,
  input  logic        capture,
  input  logic        use_stored,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] operand_b
);

  // first memory operand of the string compare
  logic [31:0] cmps_first_mem;

  // loaded by the first CMPS micro-op, held until the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      cmps_first_mem <= 32'h0000_0000;
    end else if (capture) begin
      cmps_first_mem <= a;
    end
  end

  // second CMPS micro-op compares against the held value
  assign operand_b = use_stored ? cmps_first_mem : b;

endmodule

// File: execute.sv
// combinational execute stage with control decode, operand select, ALU and writeback bundle
`timescale 1ns/1ps

module execute (
  input  logic             clk,
  input  logic             reset,
  input  ex_pkg::ex_uop_t  ex_uop,
  input  logic             wb_stall,
  output ex_pkg::wb_uop_t  wb_next
);
  import ex_pkg::*;

  cs_fields_t  cs_fields;
  logic        cmps_capture;
  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic [31:0] alu_flags;

  control_store_decode control_store_decode_i (
    .control_store (ex_uop.control_store),
    .cs_fields     (cs_fields)
  );

  // only a micro-op actually taken may update the CMPS register
  assign cmps_capture = ex_uop.valid & cs_fields.cmps_first & ~wb_stall;

  cmps_operand_select cmps_operand_select_i (
    .clk        (clk),
    .reset      (reset),
    .capture    (cmps_capture),
    .use_stored (cs_fields.cmps_second),
    .a          (ex_uop.a),
    .b          (ex_uop.b),
    .operand_b  (operand_b)
  );

  // operand A straight from register read
  alu32 alu32_i (
    .a        (ex_uop.a),
    .b        (operand_b),
    .aluk     (ex_uop.aluk),
    .datasize (ex_uop.datasize),
    .result   (alu_result),
    .flags    (alu_flags)
  );

  always_comb begin
    wb_next.valid          = ex_uop.valid;
    wb_next.neip           = ex_uop.neip;
    wb_next.ncs            = ex_uop.ncs;
    wb_next.control_store  = ex_uop.control_store;
    wb_next.datasize       = ex_uop.datasize;
    wb_next.aluk           = ex_uop.aluk;
    wb_next.ld_gpr1        = ex_uop.ld_gpr1;
    wb_next.dcache_write   = ex_uop.dcache_write;
    wb_next.flags_affected = ex_uop.flags_affected;
    wb_next.alu_result     = alu_result;
    wb_next.flags          = alu_flags;
    // string pointer for the writeback update
    wb_next.cmps_pointer   = ex_uop.b;
    wb_next.count          = ex_uop.count;
    wb_next.dr1            = ex_uop.dr1;
    wb_next.dr2            = ex_uop.dr2;
    wb_next.dr3            = ex_uop.dr3;
  end

endmodule

// File: ex_wb_latch.sv
// execute to writeback pipeline register with valid and stall
`timescale 1ns/1ps

module ex_wb_latch (
  input  logic             clk,
  input  logic             reset,
  input  logic             wb_stall,
  input  ex_pkg::wb_uop_t  wb_next,
  output ex_pkg::wb_uop_t  wb_uop
);
  import ex_pkg::*;

  logic    valid_q;
  wb_uop_t payload_q;

  // valid follows the input on every unstalled edge
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (!wb_stall) begin
      valid_q <= wb_next.valid;
    end
  end

  // payload only moves for a real micro-op
  always_ff @(posedge clk) begin
    if (!wb_stall && wb_next.valid) begin
      payload_q <= wb_next;
    end
  end

  always_comb begin
    wb_uop       = payload_q;
    wb_uop.valid = valid_q;
  end

endmodule

// File: ex_stage_top.sv
// execute stage top level with the combinational execute and the writeback latch
`timescale 1ns/1ps

module ex_stage_top (
  input  logic             clk,
  input  logic             reset,
  input  ex_pkg::ex_uop_t  ex_uop,
  input  logic             wb_stall,
  output ex_pkg::wb_uop_t  wb_uop
);
  import ex_pkg::*;

  // execute result before the pipeline register
  wb_uop_t wb_next;

  execute execute_i (
    .clk      (clk),
    .reset    (reset),
    .ex_uop   (ex_uop),
    .wb_stall (wb_stall),
    .wb_next  (wb_next)
  );

  ex_wb_latch ex_wb_latch_i (
    .clk      (clk),
    .reset    (reset),
    .wb_stall (wb_stall),
    .wb_next  (wb_next),
    .wb_uop   (wb_uop)
  );

endmodule

// File: execute_chk.sv
// concurrent checks on the writeback latch for reset, stall hold and invalid propagation
`timescale 1ns/1ps

module execute_chk (
  input logic            clk,
  input logic            reset,
  input logic            wb_stall,
  input ex_pkg::wb_uop_t wb_next,
  input ex_pkg::wb_uop_t wb_uop
);

  // valid clears on the edge that sees reset
  property reset_clears_valid;
    @(posedge clk) reset |=> !wb_uop.valid;
  endproperty

  // stall freezes the whole output bundle
  property stall_holds_output;
    @(posedge clk) disable iff (reset)
      wb_stall |=> $stable(wb_uop);
  endproperty

  // a bubble taken by the latch stays a bubble
  property bubble_gives_invalid;
    @(posedge clk) disable iff (reset)
      (!wb_stall && !wb_next.valid) |=> !wb_uop.valid;
  endproperty

  reset_clears_valid_a: assert property (reset_clears_valid)
    else $error("wb_uop.valid is set in the cycle after reset");

  stall_holds_output_a: assert property (stall_holds_output)
    else $error("wb_uop changed while wb_stall was high");

  bubble_gives_invalid_a: assert property (bubble_gives_invalid)
    else $error("wb_uop.valid is set after an invalid unstalled input");

endmodule

// File: tb_execute.sv
// execute stage testbench with clock, reset, stimulus, ALU reference model and checks
`timescale 1ns/1ps
`include "ex_config.svh"

module tb_execute;
  import ex_pkg::*;

  logic        clk;
  logic        reset;
  logic        wb_stall;
  ex_uop_t     ex_uop;
  wb_uop_t     wb_uop;
  integer      seed;
  logic [31:0] cmps_stored;

  ex_stage_top ex_stage_top_i (
    .clk      (clk),
    .reset    (reset),
    .ex_uop   (ex_uop),
    .wb_stall (wb_stall),
    .wb_uop   (wb_uop)
  );

  bind ex_wb_latch execute_chk execute_chk_i (
    .clk      (clk),
    .reset    (reset),
    .wb_stall (wb_stall),
    .wb_next  (wb_next),
    .wb_uop   (wb_uop)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_and_stop();
    $display("Something failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_word(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      fail_and_stop();
    end
  endtask

  task automatic check_uop(input string name, input wb_uop_t expected, input wb_uop_t actual);
    assert (actual === expected) else begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      fail_and_stop();
    end
  endtask

  // reference ALU with flags from widened and signed arithmetic at the selected width
  function automatic void alu_model(input logic [31:0] a, input logic [31:0] b,
                                    input alu_op_e op, input data_size_e size,
                                    output logic [31:0] res, output logic [31:0] fl);
    logic [31:0] mask;
    int          top;
    longint      sa;
    longint      sb;
    longint      sr;
    longint      smax;
    logic        arith;
    logic        is_sub;
    case (size)
      size_byte: begin
        mask = 32'h0000_00ff;
        top  = 7;
        sa   = longint'($signed(a[7:0]));
        sb   = longint'($signed(b[7:0]));
      end
      size_word: begin
        mask = 32'h0000_ffff;
        top  = 15;
        sa   = longint'($signed(a[15:0]));
        sb   = longint'($signed(b[15:0]));
      end
      default: begin
        mask = 32'hffff_ffff;
        top  = 31;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
      end
    endcase
    smax   = (64'sd1 <<< top) - 64'sd1;
    arith  = (op == alu_add) || (op == alu_sub);
    is_sub = (op == alu_sub);
    case (op)
      alu_add:    res = a + b;
      alu_sub:    res = a - b;
      alu_or:     res = a | b;
      alu_and:    res = a & b;
      alu_xor:    res = a ^ b;
      alu_not_a:  res = ~a;
      alu_pass_b: res = b;
      default:    res = a;
    endcase
    sr = is_sub ? (sa - sb) : (sa + sb);
    fl = 32'h0;
    if (arith) begin
      if (is_sub) begin
        fl[`FLAG_CF] = (a & mask) < (b & mask);
        fl[`FLAG_AF] = a[3:0] < b[3:0];
      end else begin
        fl[`FLAG_CF] = ({1'b0, a & mask} + {1'b0, b & mask}) > {1'b0, mask};
        fl[`FLAG_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'h0f;
      end
      fl[`FLAG_OF] = (sr > smax) || (sr < (-smax - 64'sd1));
    end
    fl[`FLAG_ZF] = (res & mask) == 32'h0;
    fl[`FLAG_SF] = res[top];
    fl[`FLAG_PF] = ~^res[7:0];
  endfunction

  function automatic wb_uop_t expected_wb(input ex_uop_t u, input logic [31:0] b_eff);
    wb_uop_t     w;
    logic [31:0] r;
    logic [31:0] f;
    alu_model(u.a, b_eff, u.aluk, u.datasize, r, f);
    w                = '0;
    w.valid          = 1'b1;
    w.neip           = u.neip;
    w.ncs            = u.ncs;
    w.control_store  = u.control_store;
    w.datasize       = u.datasize;
    w.aluk           = u.aluk;
    w.ld_gpr1        = u.ld_gpr1;
    w.dcache_write   = u.dcache_write;
    w.flags_affected = u.flags_affected;
    w.alu_result     = r;
    w.flags          = f;
    w.cmps_pointer   = u.b;
    w.count          = u.count;
    w.dr1            = u.dr1;
    w.dr2            = u.dr2;
    w.dr3            = u.dr3;
    return w;
  endfunction

  task automatic make_random_uop(input alu_op_e op, input data_size_e size, output ex_uop_t u);
    logic [31:0] r;
    u               = '0;
    u.valid         = 1'b1;
    u.neip          = $random(seed);
    r               = $random(seed);
    u.ncs           = r[15:0];
    u.control_store = {$random(seed), $random(seed)};
    // no CMPS unless a test asks for it
    u.control_store[`CS_BIT_CMPS_FIRST]  = 1'b0;
    u.control_store[`CS_BIT_CMPS_SECOND] = 1'b0;
    u.datasize       = size;
    u.aluk           = op;
    r                = $random(seed);
    u.mem_wr         = r[0];
    u.ld_gpr1        = r[1];
    u.dcache_write   = r[2];
    u.flags_affected = r[9:3];
    u.dr1            = r[12:10];
    u.dr2            = r[15:13];
    u.dr3            = r[18:16];
    u.a              = $random(seed);
    u.b              = $random(seed);
    u.count          = $random(seed);
    u.address        = $random(seed);
  endtask

  // one unstalled micro-op through the stage and back to idle
  task automatic run_uop(input ex_uop_t u);
    wb_uop_t     exp;
    logic [31:0] b_eff;
    int          waited;
    b_eff = u.b;
    if (u.control_store[`CS_BIT_CMPS_SECOND] && !u.control_store[`CS_BIT_CMPS_FIRST]) begin
      b_eff = cmps_stored;
    end
    exp = expected_wb(u, b_eff);
    @(negedge clk);
    ex_uop = u;
    waited = 0;
    @(negedge clk);
    while (!wb_uop.valid && waited < 20) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (!wb_uop.valid) begin
      $display("timed out waiting for wb_uop.valid after a valid micro-op");
      fail_and_stop();
    end
    check_word("wb_uop.alu_result", 64'(exp.alu_result), 64'(wb_uop.alu_result));
    check_word("wb_uop.flags", 64'(exp.flags), 64'(wb_uop.flags));
    check_word("wb_uop.cmps_pointer", 64'(u.b), 64'(wb_uop.cmps_pointer));
    check_uop("wb_uop", exp, wb_uop);
    ex_uop.valid = 1'b0;
    if (u.control_store[`CS_BIT_CMPS_FIRST] && !u.control_store[`CS_BIT_CMPS_SECOND]) begin
      cmps_stored = u.a;
    end
  endtask

  initial begin
    ex_uop_t     u;
    wb_uop_t     held;
    wb_uop_t     exp_stall;
    logic [31:0] first_a;
    logic [31:0] diff;
    logic [31:0] mask;
    logic [31:0] top_val;
    logic [31:0] upper;
    logic [2:0]  opsel;
    data_size_e  size;
    seed        = 32'h9370;
    cmps_stored = 32'h0;
    reset       = 1'b1;
    wb_stall    = 1'b0;
    ex_uop      = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // idle after reset
    repeat (3) begin
      @(negedge clk);
      check_word("wb_uop.valid", 64'h0, 64'(wb_uop.valid));
    end

    for (int i = 0; i < 40; i++) begin
      opsel = i[2:0];
      make_random_uop(alu_op_e'(opsel), size_dword, u);
      run_uop(u);
    end

    // narrow widths around the sign and carry boundaries
    for (int s = 0; s < 2; s++) begin
      for (int k = 0; k < 4; k++) begin
        size    = (s == 0) ? size_byte : size_word;
        mask    = (s == 0) ? 32'h0000_00ff : 32'h0000_ffff;
        top_val = (s == 0) ? 32'h0000_0080 : 32'h0000_8000;
        upper   = 32'ha5a5_a5a5 & ~mask;
        make_random_uop((k < 2) ? alu_add : alu_sub, size, u);
        case (k)
          0:       u.a = upper | (top_val - 32'h1);
          1:       u.a = upper | mask;
          2:       u.a = upper;
          default: u.a = upper | top_val;
        endcase
        u.b = (u.b & ~mask) | 32'h1;
        run_uop(u);
      end
    end

    // CMPS pair with idle cycles in between
    make_random_uop(alu_pass_a, size_dword, u);
    u.control_store[`CS_BIT_CMPS_FIRST] = 1'b1;
    run_uop(u);
    first_a = u.a;
    repeat (3) @(negedge clk);
    make_random_uop(alu_sub, size_dword, u);
    u.control_store[`CS_BIT_CMPS_SECOND] = 1'b1;
    run_uop(u);
    diff = u.a - first_a;
    check_word("wb_uop.alu_result", 64'(diff), 64'(wb_uop.alu_result));

    // stall holds the latch and release lets the held input through
    make_random_uop(alu_xor, size_dword, u);
    run_uop(u);
    // the bubble after the xor leaves its payload with valid low
    held       = expected_wb(u, u.b);
    held.valid = 1'b0;
    make_random_uop(alu_add, size_word, u);
    exp_stall = expected_wb(u, u.b);
    @(negedge clk);
    ex_uop   = u;
    wb_stall = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_uop("wb_uop", held, wb_uop);
    end
    wb_stall = 1'b0;
    @(negedge clk);
    check_uop("wb_uop", exp_stall, wb_uop);
    ex_uop.valid = 1'b0;
    repeat (2) @(negedge clk);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: build.f
+incdir+.
ex_pkg.sv
control_store_decode.sv
alu32.sv
cmps_operand_select.sv
execute.sv
ex_wb_latch.sv
ex_stage_top.sv
execute_chk.sv
tb_execute.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module tb_execute -f build.f
	@out=$$(./obj_dir/Vtb_execute); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
